// File: include/exec_config.svh
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

`define EX_WIDTH      16

`define EX_OP_ROL     3'd0
`define EX_OP_SLL     3'd1
`define EX_OP_ROR     3'd2
`define EX_OP_SRL     3'd3
`define EX_OP_ADD     3'd4
`define EX_OP_AND     3'd5
`define EX_OP_OR      3'd6
`define EX_OP_XOR     3'd7

`define EX_BR_EQZ     2'd0
`define EX_BR_NEZ     2'd1
`define EX_BR_LTZ     2'd2
`define EX_BR_GEZ     2'd3

`define EX_SET_OFL    2'd0
`define EX_SET_EQ     2'd1
`define EX_SET_LT     2'd2
`define EX_SET_LE     2'd3

`define EX_RES_ALU    3'd0
`define EX_RES_SET    3'd1
`define EX_RES_LBI    3'd2
`define EX_RES_SLBI   3'd3
`define EX_RES_LINK   3'd4

`endif

// File: logic/exec_pkg.sv
`default_nettype none

`include "exec_config.svh"

package exec_pkg;

   typedef logic [`EX_WIDTH-1:0] word_t;
   typedef logic [2:0]           alu_op_t;
   typedef logic [1:0]           br_cond_t;
   typedef logic [1:0]           set_sel_t;
   typedef logic [2:0]           res_sel_t;

   // ########################################################################
   // Decoded control and issue packet.
   // ########################################################################
   typedef struct packed {
      alu_op_t  alu_op;
      logic     inv_a;
      logic     inv_b;
      logic     cin;
      logic     sign;           // Signed compare and overflow.
      set_sel_t set_sel;
      br_cond_t br_cond;
      logic     br_instr;
      logic     jmp_instr;
      logic     jmp_reg_instr;  // Target comes from the ALU.
      res_sel_t res_sel;
   } ex_ctrl_t;

   typedef struct packed {
      logic ex_fwd_rs;
      logic ex_fwd_rt;
      logic mem_fwd_rs;
      logic mem_fwd_rt;
   } ex_fwd_t;

   typedef struct packed {
      logic     valid;
      ex_ctrl_t ctrl;
      word_t    oprnd_1;
      word_t    oprnd_2;
      word_t    sext_imm;
      word_t    pc_inc;
   } ex_in_t;

   // ########################################################################
   // Stage outputs.
   // ########################################################################
   typedef struct packed {
      logic zero;
      logic ofl;
      logic ltz;
      logic lteq;
      logic op_a_neg;
   } alu_flags_t;

   typedef struct packed {
      logic  valid;
      word_t result;
      word_t store_data;
   } ex_mem_t;

   typedef struct packed {
      logic  take;
      word_t target;
   } redirect_t;

endpackage

`default_nettype wire

// File: logic/alu_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_config.svh"

module alu_unit
   import exec_pkg::*;
(
   input  ex_in_t     ex_in,
   input  ex_fwd_t    fwd,
   input  word_t      ex_rs_val,
   input  word_t      ex_rt_val,
   input  word_t      mem_rs_val,
   input  word_t      mem_rt_val,
   output word_t      alu_out,
   output word_t      op_a,
   output word_t      op_b,
   output alu_flags_t flags
);

   localparam int W = `EX_WIDTH;

   word_t            in_a;
   word_t            in_b;
   logic [3:0]       shamt;
   logic [W:0]       sum_ext;
   logic [2*W-1:0]   rol_ext;
   logic [2*W-1:0]   ror_ext;
   logic             is_add;
   logic             signed_ovf;

   // ########################################################################
   // Operand forwarding.
   // ########################################################################
   always_comb begin
      if (fwd.ex_fwd_rs) begin
         op_a = ex_rs_val;              // Youngest value wins.
      end else if (fwd.mem_fwd_rs) begin
         op_a = mem_rs_val;
      end else begin
         op_a = ex_in.oprnd_1;
      end
   end

   always_comb begin
      if (fwd.ex_fwd_rt) begin
         op_b = ex_rt_val;
      end else if (fwd.mem_fwd_rt) begin
         op_b = mem_rt_val;
      end else begin
         op_b = ex_in.oprnd_2;
      end
   end

   assign in_a  = ex_in.ctrl.inv_a ? ~op_a : op_a;
   assign in_b  = ex_in.ctrl.inv_b ? ~op_b : op_b;
   assign shamt = in_b[3:0];

   // ########################################################################
   // Datapath.
   // ########################################################################
   assign sum_ext = {1'b0, in_a} + {1'b0, in_b} + {{W{1'b0}}, ex_in.ctrl.cin};
   assign rol_ext = {in_a, in_a} << shamt;    // Upper half is the rotate.
   assign ror_ext = {in_a, in_a} >> shamt;    // Lower half is the rotate.

   always_comb begin
      case (ex_in.ctrl.alu_op)
         `EX_OP_ROL: alu_out = rol_ext[2*W-1:W];
         `EX_OP_SLL: alu_out = in_a << shamt;
         `EX_OP_ROR: alu_out = ror_ext[W-1:0];
         `EX_OP_SRL: alu_out = in_a >> shamt;
         `EX_OP_ADD: alu_out = sum_ext[W-1:0];
         `EX_OP_AND: alu_out = in_a & in_b;
         `EX_OP_OR:  alu_out = in_a | in_b;
         `EX_OP_XOR: alu_out = in_a ^ in_b;
         default:    alu_out = '0;
      endcase
   end

   // Flags.
   assign is_add     = (ex_in.ctrl.alu_op == `EX_OP_ADD);
   assign signed_ovf = (in_a[W-1] ~^ in_b[W-1]) & (sum_ext[W-1] ^ in_a[W-1]);

   assign flags.zero     = ~|alu_out;
   assign flags.ofl      = is_add & (ex_in.ctrl.sign ? signed_ovf : sum_ext[W]);
   assign flags.ltz      = ex_in.ctrl.sign ? (alu_out[W-1] ^ flags.ofl) : alu_out[W-1];
   assign flags.lteq     = flags.ltz | flags.zero;
   assign flags.op_a_neg = op_a[W-1];  // Before inversion.

endmodule

`default_nettype wire

// File: logic/branch_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_config.svh"

module branch_unit
   import exec_pkg::*;
(
   input  ex_in_t     ex_in,
   input  word_t      alu_out,
   input  alu_flags_t flags,
   output logic       take,
   output word_t      target
);

   logic  cond_met;
   word_t pc_rel;

   // Condition select.
   always_comb begin
      case (ex_in.ctrl.br_cond)
         `EX_BR_EQZ: cond_met = flags.zero;
         `EX_BR_NEZ: cond_met = ~flags.zero;
         `EX_BR_LTZ: cond_met = flags.op_a_neg;
         `EX_BR_GEZ: cond_met = ~flags.op_a_neg;
         default:    cond_met = 1'b0;
      endcase
   end

   assign take = ex_in.ctrl.jmp_instr
               | ex_in.ctrl.jmp_reg_instr
               | (ex_in.ctrl.br_instr & cond_met);

   // ########################################################################
   // Target.
   // ########################################################################
   assign pc_rel = ex_in.pc_inc + ex_in.sext_imm;  // Wraps at 16 bits.

   always_comb begin
      if (ex_in.ctrl.jmp_reg_instr) begin
         target = alu_out;                          // Register plus offset.
      end else begin
         target = pc_rel;
      end
   end

endmodule

`default_nettype wire

// File: logic/ex_mem_stage.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_config.svh"

module ex_mem_stage
   import exec_pkg::*;
(
   input  logic       clk,
   input  logic       arst_n,
   input  ex_in_t     ex_in,
   input  word_t      alu_out,
   input  word_t      op_a,
   input  word_t      op_b,
   input  alu_flags_t flags,
   input  logic       take,
   input  word_t      target,
   input  logic       stall,
   input  logic       flush,
   output ex_mem_t    ex_mem,
   output redirect_t  redirect
);

   logic  set_bit;
   word_t result;
   logic  valid_q;
   logic  take_q;
   word_t result_q;
   word_t store_q;
   word_t target_q;

   // ########################################################################
   // Result select.
   // ########################################################################
   always_comb begin
      case (ex_in.ctrl.set_sel)
         `EX_SET_OFL: set_bit = flags.ofl;
         `EX_SET_EQ:  set_bit = flags.zero;
         `EX_SET_LT:  set_bit = flags.ltz;
         default:     set_bit = flags.lteq;
      endcase
   end

   always_comb begin
      case (ex_in.ctrl.res_sel)
         `EX_RES_SET:  result = {{(`EX_WIDTH-1){1'b0}}, set_bit};
         `EX_RES_LBI:  result = ex_in.sext_imm;
         `EX_RES_SLBI: result = {op_a[7:0], ex_in.sext_imm[7:0]};
         `EX_RES_LINK: result = ex_in.pc_inc;   // Return address.
         default:      result = alu_out;
      endcase
   end

   // ########################################################################
   // Execute/memory register.
   // ########################################################################
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_q <= 1'b0;
         take_q  <= 1'b0;
      end else if (flush) begin
         valid_q <= 1'b0;                 // Flush beats stall.
         take_q  <= 1'b0;
      end else if (stall) begin
         take_q  <= 1'b0;                 // No repeated redirect.
      end else begin
         valid_q <= ex_in.valid;
         take_q  <= ex_in.valid & take;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         result_q <= result;
         store_q  <= op_b;
         target_q <= target;
      end
   end

   assign ex_mem.valid      = valid_q;
   assign ex_mem.result     = result_q;
   assign ex_mem.store_data = store_q;
   assign redirect.take     = take_q;
   assign redirect.target   = target_q;

endmodule

`default_nettype wire

// File: logic/execute_top.sv
`timescale 1ns/100ps
`default_nettype none

module execute_top
   import exec_pkg::*;
(
   input  logic      clk,
   input  logic      arst_n,
   input  ex_in_t    ex_in,
   input  ex_fwd_t   fwd,
   input  word_t     ex_rs_val,
   input  word_t     ex_rt_val,
   input  word_t     mem_rs_val,
   input  word_t     mem_rt_val,
   input  logic      stall,
   input  logic      flush,
   output ex_mem_t   ex_mem,
   output redirect_t redirect
);

   word_t      alu_out;
   word_t      op_a;
   word_t      op_b;
   alu_flags_t flags;
   logic       take;
   word_t      target;

   alu_unit i_alu_unit (
      .ex_in      (ex_in),
      .fwd        (fwd),
      .ex_rs_val  (ex_rs_val),
      .ex_rt_val  (ex_rt_val),
      .mem_rs_val (mem_rs_val),
      .mem_rt_val (mem_rt_val),
      .alu_out    (alu_out),
      .op_a       (op_a),
      .op_b       (op_b),
      .flags      (flags)
   );

   branch_unit i_branch_unit (
      .ex_in   (ex_in),
      .alu_out (alu_out),
      .flags   (flags),
      .take    (take),
      .target  (target)
   );

   ex_mem_stage i_ex_mem_stage (
      .clk      (clk),
      .arst_n   (arst_n),
      .ex_in    (ex_in),
      .alu_out  (alu_out),
      .op_a     (op_a),
      .op_b     (op_b),
      .flags    (flags),
      .take     (take),
      .target   (target),
      .stall    (stall),
      .flush    (flush),
      .ex_mem   (ex_mem),
      .redirect (redirect)
   );

endmodule

`default_nettype wire

// File: testbench/execute_assert.sv
`timescale 1ns/100ps
`default_nettype none

module execute_assert
   import exec_pkg::*;
(
   input logic      clk,
   input logic      arst_n,
   input ex_in_t    ex_in,
   input logic      take,
   input logic      stall,
   input logic      flush,
   input ex_mem_t   ex_mem,
   input redirect_t redirect
);

   int fail_count = 0;  // Read by the testbench at the end.

   // ########################################################################
   // Reset and latency.
   // ########################################################################
   reset_idle: assert property (@(posedge clk)
      !arst_n |-> (!ex_mem.valid && !redirect.take))
      else begin
         $error("Stage output active while in reset.");
         fail_count++;
      end

   one_cycle_latency: assert property (@(posedge clk) disable iff (!arst_n)
      (ex_in.valid && !stall && !flush) |=> ex_mem.valid)
      else begin
         $error("Issued instruction did not reach the register after one cycle.");
         fail_count++;
      end

   // ########################################################################
   // Redirect pulse, stall and flush.
   // ########################################################################
   take_pulse: assert property (@(posedge clk) disable iff (!arst_n)
      redirect.take |-> $past(ex_in.valid && take && !stall && !flush))
      else begin
         $error("Redirect raised without a fresh taken instruction.");
         fail_count++;
      end

   stall_holds: assert property (@(posedge clk) disable iff (!arst_n)
      (stall && !flush) |=> ((ex_mem == $past(ex_mem)) && !redirect.take))
      else begin
         $error("Register changed or redirect fired during a stall.");
         fail_count++;
      end

   flush_clears: assert property (@(posedge clk) disable iff (!arst_n)
      flush |=> (!ex_mem.valid && !redirect.take))
      else begin
         $error("Flush did not clear valid and redirect.");
         fail_count++;
      end

endmodule

bind execute_top execute_assert i_execute_assert (
   .clk      (clk),
   .arst_n   (arst_n),
   .ex_in    (ex_in),
   .take     (take),
   .stall    (stall),
   .flush    (flush),
   .ex_mem   (ex_mem),
   .redirect (redirect)
);

`default_nettype wire

// File: testbench/tb_execute.sv
`timescale 1ns/100ps
`default_nettype none

`include "exec_config.svh"

module tb_execute
   import exec_pkg::*;
();

   localparam int CLK_PERIOD   = 100;
   localparam int RESET_CYCLES = 3;
   localparam int N_ALU        = 300;
   localparam int N_SET        = 60;
   localparam int N_FWD        = 80;
   localparam int N_BR         = 80;
   localparam int N_IMM        = 45;
   localparam int N_STALL      = 60;
   localparam int TIMEOUT_CYCLES = RESET_CYCLES + N_ALU + N_SET + N_FWD + N_BR + N_IMM
                                 + N_STALL + 50;

   typedef struct packed {
      logic  valid;
      word_t result;
      word_t store;
      logic  take;
      word_t target;
   } expect_t;

   logic      clk;
   logic      arst_n;
   ex_in_t    ex_in;
   ex_fwd_t   fwd;
   word_t     ex_rs_val;
   word_t     ex_rt_val;
   word_t     mem_rs_val;
   word_t     mem_rt_val;
   logic      stall;
   logic      flush;
   ex_mem_t   ex_mem;
   redirect_t redirect;

   logic [31:0] rng_state;
   int          error_count;
   int          cycle_count;
   logic        pending;        // A result is due at the next falling edge.
   expect_t     pending_exp;
   string       pending_name;

   execute_top i_execute_top (
      .clk        (clk),
      .arst_n     (arst_n),
      .ex_in      (ex_in),
      .fwd        (fwd),
      .ex_rs_val  (ex_rs_val),
      .ex_rt_val  (ex_rt_val),
      .mem_rs_val (mem_rs_val),
      .mem_rt_val (mem_rt_val),
      .stall      (stall),
      .flush      (flush),
      .ex_mem     (ex_mem),
      .redirect   (redirect)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // ########################################################################
   // Random source.
   // ########################################################################
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function logic [31:0] rand32();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic word_t rand_word();
      logic [31:0] r;
      r = rand32();
      return r[15:0];
   endfunction

   function automatic ex_in_t random_instr();
      ex_in_t      ins;
      logic [31:0] r;
      r = rand32();
      ins.valid              = 1'b1;
      ins.ctrl               = r[$bits(ex_ctrl_t)-1:0];
      ins.ctrl.br_instr      = 1'b0;
      ins.ctrl.jmp_instr     = 1'b0;
      ins.ctrl.jmp_reg_instr = 1'b0;
      ins.ctrl.res_sel       = `EX_RES_ALU;
      ins.oprnd_1            = rand_word();
      ins.oprnd_2            = rand_word();
      ins.sext_imm           = rand_word();
      ins.pc_inc             = rand_word();
      if (r[31:28] == 4'd0) begin
         ins.oprnd_2 = ins.oprnd_1;  // Makes zero results likely.
      end
      return ins;
   endfunction

   function automatic ex_in_t zero_result(input ex_in_t ins);
      ex_in_t z;
      z             = ins;
      z.ctrl.alu_op = `EX_OP_XOR;      // Equal operands cancel.
      z.ctrl.inv_b  = ins.ctrl.inv_a;
      z.oprnd_2     = ins.oprnd_1;
      return z;
   endfunction

   // ########################################################################
   // Reference model.
   // ########################################################################
   function automatic expect_t model(input ex_in_t ins, input ex_fwd_t f, input word_t ers,
                                     input word_t ert, input word_t mrs, input word_t mrt);
      word_t       a;
      word_t       b;
      word_t       ia;
      word_t       ib;
      word_t       out;
      logic [16:0] sum;
      int          s_sum;
      int          amt;
      int          i;
      logic        zero;
      logic        ofl;
      logic        ltz;
      logic        set_bit;
      logic        cond;
      expect_t     e;
      a     = f.ex_fwd_rs ? ers : (f.mem_fwd_rs ? mrs : ins.oprnd_1);
      b     = f.ex_fwd_rt ? ert : (f.mem_fwd_rt ? mrt : ins.oprnd_2);
      ia    = ins.ctrl.inv_a ? ~a : a;
      ib    = ins.ctrl.inv_b ? ~b : b;
      amt   = int'(ib[3:0]);
      sum   = 17'(ia) + 17'(ib) + 17'(ins.ctrl.cin);
      s_sum = int'($signed(ia)) + int'($signed(ib)) + int'(ins.ctrl.cin);
      out   = ia;
      case (ins.ctrl.alu_op)
         `EX_OP_ROL: for (i = 0; i < amt; i++) out = {out[14:0], out[15]};
         `EX_OP_SLL: out = ia << ib[3:0];
         `EX_OP_ROR: for (i = 0; i < amt; i++) out = {out[0], out[15:1]};
         `EX_OP_SRL: out = ia >> ib[3:0];
         `EX_OP_ADD: out = sum[15:0];
         `EX_OP_AND: out = ia & ib;
         `EX_OP_OR:  out = ia | ib;
         default:    out = ia ^ ib;
      endcase
      zero = (out == 16'd0);
      ofl  = 1'b0;
      if (ins.ctrl.alu_op == `EX_OP_ADD) begin
         ofl = ins.ctrl.sign ? (s_sum > 32767 || s_sum < -32768) : sum[16];
      end
      ltz = ins.ctrl.sign ? (out[15] ^ ofl) : out[15];
      case (ins.ctrl.set_sel)
         `EX_SET_OFL: set_bit = ofl;
         `EX_SET_EQ:  set_bit = zero;
         `EX_SET_LT:  set_bit = ltz;
         default:     set_bit = ltz | zero;
      endcase
      case (ins.ctrl.br_cond)
         `EX_BR_EQZ: cond = zero;
         `EX_BR_NEZ: cond = !zero;
         `EX_BR_LTZ: cond = a[15];
         default:    cond = !a[15];
      endcase
      e.valid  = ins.valid;
      e.take   = ins.valid & (ins.ctrl.jmp_instr | ins.ctrl.jmp_reg_instr
                            | (ins.ctrl.br_instr & cond));
      e.target = ins.ctrl.jmp_reg_instr ? out : ins.pc_inc + ins.sext_imm;
      e.store  = b;
      case (ins.ctrl.res_sel)
         `EX_RES_SET:  e.result = {15'd0, set_bit};
         `EX_RES_LBI:  e.result = ins.sext_imm;
         `EX_RES_SLBI: e.result = {a[7:0], ins.sext_imm[7:0]};
         `EX_RES_LINK: e.result = ins.pc_inc;
         default:      e.result = out;
      endcase
      return e;
   endfunction

   // ########################################################################
   // Checks and stimulus.
   // ########################################################################
   task automatic check_bit(input string name, input logic expected, input logic actual);
      assert (actual === expected) else begin
         $display("ERROR %s: expected %b, actual %b", name, expected, actual);
         error_count = error_count + 1;
      end
   endtask

   task automatic check_word(input string name, input word_t expected, input word_t actual);
      assert (actual === expected) else begin
         $display("ERROR %s: expected %h, actual %h", name, expected, actual);
         error_count = error_count + 1;
      end
   endtask

   task automatic compare_outputs(input string name, input expect_t e);
      check_bit({name, " valid"}, e.valid, ex_mem.valid);
      check_word({name, " result"}, e.result, ex_mem.result);
      check_word({name, " store_data"}, e.store, ex_mem.store_data);
      check_bit({name, " take"}, e.take, redirect.take);
      check_word({name, " target"}, e.target, redirect.target);
   endtask

   task automatic apply(input string name, input ex_in_t ins, input ex_fwd_t f,
                        input logic st, input logic fl, input logic chk);
      @(negedge clk);
      if (pending) begin
         compare_outputs(pending_name, pending_exp);
      end
      ex_in      = ins;
      fwd        = f;
      stall      = st;
      flush      = fl;
      ex_rs_val  = rand_word();
      ex_rt_val  = rand_word();
      mem_rs_val = rand_word();
      mem_rt_val = rand_word();
      pending      = chk;
      pending_name = name;
      pending_exp  = model(ins, f, ex_rs_val, ex_rt_val, mem_rs_val, mem_rt_val);
   endtask

   // Kind 0 ALU, 1 set, 2 forwarding, 3 branch, 4 immediates, 5 stall and flush.
   task automatic run_phase(input string name, input int count, input int kind);
      ex_in_t      ins;
      ex_fwd_t     f;
      logic        st;
      logic        fl;
      logic [31:0] r;
      for (int n = 0; n < count; n++) begin
         ins = random_instr();
         r   = rand32();
         f   = '0;
         st  = 1'b0;
         fl  = 1'b0;
         if (kind == 1) begin
            ins.ctrl.res_sel = `EX_RES_SET;
            if (r[0]) ins.ctrl.alu_op = `EX_OP_ADD;  // Overflow needs an add.
            if (n % 4 == 3) begin
               ins              = zero_result(ins);
               ins.ctrl.set_sel = set_sel_t'(n / 4 % 4);
            end
         end
         if (kind >= 2) f = r[11:8];
         if (kind == 2 && r[13:12] == 2'd0) f = 4'b1111;  // Both levels at once.
         if (kind == 3 || kind == 5) begin
            ins.ctrl.br_instr      = (r[1:0] == 2'd0);
            ins.ctrl.jmp_instr     = (r[1:0] == 2'd1);
            ins.ctrl.jmp_reg_instr = (r[1:0] == 2'd2);
            ins.valid              = (r[4:2] != 3'd0);
         end
         if (kind == 3 && n % 4 == 0) begin
            ins                    = zero_result(ins);  // Branch on a zero result.
            f                      = '0;
            ins.ctrl.br_instr      = 1'b1;
            ins.ctrl.jmp_instr     = 1'b0;
            ins.ctrl.jmp_reg_instr = 1'b0;
            ins.ctrl.br_cond       = br_cond_t'(n / 4 % 4);
         end
         if (kind == 4) ins.ctrl.res_sel = res_sel_t'(`EX_RES_LBI + n % 3);
         if (kind == 5) begin
            st = r[5] & r[6];
            fl = (r[9:7] == 3'd0) || (n % 17 == 5);
            if (n % 17 == 5) st = 1'b1;  // Flush over stall.
         end
         apply(name, ins, f, st, fl, kind != 5);
      end
   endtask

   initial begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES) begin
         @(posedge clk);
         cycle_count = cycle_count + 1;
      end
      $display("Timeout after %0d cycles, the run did not reach its end.", cycle_count);
      $display("CHECKS FAILED");
      $finish;
   end

   initial begin
      rng_state    = 32'hc932_036b;
      error_count  = 0;
      pending      = 1'b0;
      pending_exp  = '0;
      pending_name = "";
      arst_n       = 1'b0;
      ex_in        = '0;
      fwd          = '0;
      ex_rs_val    = '0;
      ex_rt_val    = '0;
      mem_rs_val   = '0;
      mem_rt_val   = '0;
      stall        = 1'b0;
      flush        = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      run_phase("alu", N_ALU, 0);
      run_phase("set", N_SET, 1);
      run_phase("forward", N_FWD, 2);
      run_phase("branch", N_BR, 3);
      run_phase("immediate", N_IMM, 4);
      run_phase("stall_flush", N_STALL, 5);
      run_phase("after_stall", 1, 0);
      @(negedge clk);
      if (pending) begin
         compare_outputs(pending_name, pending_exp);
      end
      $display("Compare errors: %0d, assertion failures: %0d", error_count,
               i_execute_top.i_execute_assert.fail_count);
      if (error_count == 0 && i_execute_top.i_execute_assert.fail_count == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+include
logic/exec_pkg.sv
logic/alu_unit.sv
logic/branch_unit.sv
logic/ex_mem_stage.sv
logic/execute_top.sv
testbench/execute_assert.sv
testbench/tb_execute.sv

// File: Makefile
TOP := tb_execute
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f -o V$(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+1000 > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "ALL CHECKS PASSED" $(LOG) || { echo "Simulation did not complete"; exit 1; }

clean:
	rm -rf obj_dir $(LOG)
